/* common/panel_pkg.sv */
// panel_pkg: shared widths, types and timing constants for the front-panel lamp test
package panel_pkg;

    // panel words use PDP-8 bit order, bit 0 is the msb
    typedef logic [0:11] word_t;
    typedef logic [0:2]  ema_t;
    typedef logic [0:5]  dsel_t;
    typedef logic [7:0]  char_t;

    localparam int NUM_KEYS = 9;              // sw .. dep, see panel_if

    // serial timing at 12 MHz
    localparam int BAUD_DIV = 104;            // about 115200 baud
    localparam int BAUD_W   = $clog2(BAUD_DIV);

    // walking lamp step period in hardware, about half a second
    localparam int LAMP_TICK = 6000000;

    // address sweep, ema and addr sit above the dropped low bits
    localparam int SWEEP_SHIFT = 10;
    localparam int SWEEP_W     = 3 + 12 + SWEEP_SHIFT;

    // transmit text layout
    localparam int    LINE_COLS  = 80;
    localparam int    COL_W      = $clog2(LINE_COLS);
    localparam char_t FIRST_CHAR = 8'h20;     // space
    localparam char_t LAST_CHAR  = 8'h7e;     // tilde
    localparam char_t CR_CHAR    = 8'h0d;
    localparam char_t LF_CHAR    = 8'h0a;

    // walking lamp seeds
    localparam word_t WALK_LEFT_SEED  = 12'o0001;  // only bit 11 lit
    localparam word_t WALK_RIGHT_SEED = 12'o4000;  // only bit 0 lit

endpackage

/* common/panel_if.sv */
// panel_if: synchronized switch register, display selects and control keys
`timescale 1ns/1ps

interface panel_if import panel_pkg::*; ();

    word_t                sr;    // switch register
    dsel_t                dsel;  // display select switches
    // sw, addr_load, extd_addr, clear, cont, exam, halt, single_step, dep
    // all active high here
    logic [0:NUM_KEYS-1]  keys;

    modport source (
        output sr,
        output dsel,
        output keys
    );

    modport sink (
        input sr,
        input dsel,
        input keys
    );

endinterface

/* logic/switch_sync.sv */
// switch_sync: two-flop synchronizer for the panel switches, active-low keys inverted
`timescale 1ns/1ps

module switch_sync import panel_pkg::*; (
    input  logic           clk12,
    input  logic           reset,
    input  word_t          sr,
    input  dsel_t          dsel,
    input  logic           dep,
    input  logic           sw,
    input  logic           single_step,
    input  logic           halt,
    input  logic           examn,
    input  logic           contn,
    input  logic           extd_addrn,
    input  logic           addr_loadn,
    input  logic           clearn,
    panel_if.source        pnl
);

    word_t                sr_meta;
    dsel_t                dsel_meta;
    logic [0:NUM_KEYS-1]  keys_meta;
    logic [0:NUM_KEYS-1]  keys_raw;

    // key order matches panel_if, the n pins are flipped to active high
    assign keys_raw = {sw, ~addr_loadn, ~extd_addrn, ~clearn, ~contn, ~examn,
                       halt, single_step, dep};

    always_ff @(posedge clk12) begin
        if (reset) begin
            sr_meta   <= '0;
            dsel_meta <= '0;
            keys_meta <= '0;
            pnl.sr    <= '0;
            pnl.dsel  <= '0;
            pnl.keys  <= '0;
        end else begin
            sr_meta   <= sr;          // first stage
            dsel_meta <= dsel;
            keys_meta <= keys_raw;
            pnl.sr    <= sr_meta;     // second stage, seen by the readers
            pnl.dsel  <= dsel_meta;
            pnl.keys  <= keys_meta;
        end
    end

endmodule

/* serial/serial_tx.sv */
// serial_tx: free-running 8N1 transmitter of printable ASCII in 80-column lines
`timescale 1ns/1ps

module serial_tx import panel_pkg::*; (
    input  logic  clk12,
    input  logic  reset,
    output logic  tx,
    output char_t tx_char
);

    typedef enum logic [1:0] {
        GEN_PRINT,
        GEN_CR,
        GEN_LF
    } gen_state_t;

    logic [BAUD_W-1:0] baud_cnt;
    logic              baud_tick;
    logic [3:0]        bit_cnt;      // 0 is the start bit, 9 the stop bit
    logic [9:0]        frame;        // shifts out lsb first
    logic              load;

    gen_state_t        gen_state;
    char_t             pr_char;      // next printable character
    logic [COL_W-1:0]  col_cnt;
    char_t             gen_char;

    assign baud_tick = (baud_cnt == '0);
    assign load      = baud_tick && (bit_cnt == 4'd9);
    assign tx        = frame[0];

    // baud rate divider
    always_ff @(posedge clk12) begin
        if (reset || baud_tick)
            baud_cnt <= BAUD_W'(BAUD_DIV - 1);
        else
            baud_cnt <= baud_cnt - 1'b1;
    end

    // frame shifter, next frame starts right after the stop bit
    always_ff @(posedge clk12) begin
        if (reset) begin
            frame   <= '1;           // line idles high
            bit_cnt <= 4'd9;
            tx_char <= '0;
        end else if (load) begin
            frame   <= {1'b1, gen_char, 1'b0};
            bit_cnt <= 4'd0;
            tx_char <= gen_char;
        end else if (baud_tick) begin
            frame   <= {1'b1, frame[9:1]};
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    always_comb begin
        case (gen_state)
            GEN_CR:  gen_char = CR_CHAR;
            GEN_LF:  gen_char = LF_CHAR;
            default: gen_char = pr_char;
        endcase
    end

    // character generator, advances once per frame
    always_ff @(posedge clk12) begin
        if (reset) begin
            gen_state <= GEN_PRINT;
            pr_char   <= FIRST_CHAR;
            col_cnt   <= '0;
        end else if (load) begin
            case (gen_state)
                GEN_PRINT: begin
                    pr_char <= (pr_char == LAST_CHAR) ? FIRST_CHAR : pr_char + 1'b1;
                    if (col_cnt == COL_W'(LINE_COLS - 1)) begin
                        col_cnt   <= '0;
                        gen_state <= GEN_CR;    // line full
                    end else begin
                        col_cnt <= col_cnt + 1'b1;
                    end
                end
                GEN_CR:  gen_state <= GEN_LF;
                default: gen_state <= GEN_PRINT;
            endcase
        end
    end

endmodule

/* serial/serial_rx.sv */
// serial_rx: 8N1 receiver with start-bit check and mid-bit sampling
`timescale 1ns/1ps

module serial_rx import panel_pkg::*; (
    input  logic  clk12,
    input  logic  reset,
    input  logic  rx,
    output char_t rx_char,
    output logic  rx_strobe
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    logic [1:0]        rx_sync;
    logic              rx_s;
    logic              rx_last;
    logic              fall;
    rx_state_t         state;
    logic [BAUD_W-1:0] baud_cnt;
    logic [2:0]        bit_idx;
    char_t             shreg;

    assign rx_s = rx_sync[1];
    assign fall = rx_last && !rx_s;

    always_ff @(posedge clk12) begin
        if (reset) begin
            rx_sync <= 2'b11;
            rx_last <= 1'b1;
        end else begin
            rx_sync <= {rx_sync[0], rx};
            rx_last <= rx_s;
        end
    end

    always_ff @(posedge clk12) begin
        if (reset) begin
            state     <= RX_IDLE;
            baud_cnt  <= '0;
            bit_idx   <= '0;
            rx_strobe <= 1'b0;
        end else begin
            rx_strobe <= 1'b0;
            if (state != RX_IDLE && baud_cnt != '0) begin
                baud_cnt <= baud_cnt - 1'b1;
            end else begin
                case (state)
                    RX_IDLE: if (fall) begin
                        baud_cnt <= BAUD_W'(BAUD_DIV / 2 - 1);   // to mid start bit
                        state    <= RX_START;
                    end
                    RX_START: begin
                        baud_cnt <= BAUD_W'(BAUD_DIV - 1);
                        bit_idx  <= '0;
                        state    <= rx_s ? RX_IDLE : RX_DATA;   // glitch, not a start
                    end
                    RX_DATA: begin
                        baud_cnt <= BAUD_W'(BAUD_DIV - 1);
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= RX_STOP;
                    end
                    default: begin
                        rx_strobe <= rx_s;     // framing error drops the char
                        state     <= RX_IDLE;
                    end
                endcase
            end
        end
    end

    // data path, lsb arrives first
    always_ff @(posedge clk12) begin
        if (state == RX_DATA && baud_cnt == '0)
            shreg <= {rx_s, shreg[7:1]};
        if (state == RX_STOP && baud_cnt == '0 && rx_s)
            rx_char <= shreg;
    end

endmodule

/* logic/panel_lamps.sv */
// panel_lamps: slow tick, walking single lamp and free-running address sweep
`timescale 1ns/1ps

module panel_lamps import panel_pkg::*; #(
    parameter int lamp_tick = LAMP_TICK
) (
    input  logic   clk12,
    input  logic   reset,
    panel_if.sink  pnl,
    output word_t  walk,
    output ema_t   ema,
    output word_t  addr
);

    localparam int TICK_W = $clog2(lamp_tick + 1);

    logic [TICK_W-1:0]  tick_cnt;
    logic               tick;
    logic [SWEEP_W-1:0] sweep_cnt;

    assign tick = (tick_cnt == '0);

    // one-cycle enable every lamp_tick clocks
    always_ff @(posedge clk12) begin
        if (reset || tick)
            tick_cnt <= TICK_W'(lamp_tick - 1);
        else
            tick_cnt <= tick_cnt - 1'b1;
    end

    always_ff @(posedge clk12) begin
        if (reset) begin
            walk <= '0;
        end else if (tick) begin
            if (pnl.dsel[4]) begin                       // toward bit 11
                walk <= (walk == '0) ? WALK_RIGHT_SEED : walk >> 1;
            end else if (pnl.dsel[3]) begin              // toward bit 0
                walk <= (walk == '0) ? WALK_LEFT_SEED : walk << 1;
            end
        end
    end

    always_ff @(posedge clk12) begin
        if (reset)
            sweep_cnt <= '0;
        else
            sweep_cnt <= sweep_cnt + 1'b1;
    end

    // low bits dropped so the lamps move slowly enough to see
    assign {ema, addr} = sweep_cnt[SWEEP_W-1:SWEEP_SHIFT];

endmodule

/* logic/display_select.sv */
// display_select: priority mux of six sources onto the registered data-lamp word
`timescale 1ns/1ps

module display_select import panel_pkg::*; (
    input  logic   clk12,
    input  logic   reset,
    panel_if.sink  pnl,
    input  char_t  tx_char,
    input  char_t  rx_char,
    input  logic   rx_strobe,
    input  word_t  walk,
    output word_t  ds
);

    char_t rx_hold;

    always_ff @(posedge clk12) begin
        if (reset)
            rx_hold <= '0;
        else if (rx_strobe)
            rx_hold <= rx_char;     // last good character
    end

    // lowest numbered select wins
    always_ff @(posedge clk12) begin
        if (reset) begin
            ds <= '0;
        end else if (pnl.dsel[0]) begin
            ds <= {4'b0000, tx_char};     // flickers at line rate
        end else if (pnl.dsel[1]) begin
            ds <= pnl.sr;
        end else if (pnl.dsel[2]) begin
            ds <= {pnl.keys, 3'b000};
        end else if (pnl.dsel[3] || pnl.dsel[4]) begin
            ds <= walk;
        end else if (pnl.dsel[5]) begin
            ds <= {4'b0000, rx_hold};
        end
    end

endmodule

/* logic/panel_test_top.sv */
// panel_test_top: front-panel lamp and switch test, serial echo lamps and lamp walker
`timescale 1ns/1ps

module panel_test_top import panel_pkg::*; #(
    parameter int lamp_tick = LAMP_TICK
) (
    input  logic  clk12,
    input  logic  reset,
    input  logic  rx,
    input  word_t sr,
    input  dsel_t dsel,
    input  logic  dep,
    input  logic  sw,
    input  logic  single_step,
    input  logic  halt,
    input  logic  examn,
    input  logic  contn,
    input  logic  extd_addrn,
    input  logic  addr_loadn,
    input  logic  clearn,
    output logic  led1,
    output logic  led2,
    output logic  runn,
    output ema_t  EMAn,
    output word_t An,
    output word_t dsn,
    output logic  tx
);

    char_t tx_char;
    char_t rx_char;
    logic  rx_strobe;
    word_t walk;
    ema_t  ema;
    word_t addr;
    word_t ds;
    logic  run;

    panel_if pnl ();

    switch_sync u_switch_sync (
        .clk12       (clk12),
        .reset       (reset),
        .sr          (sr),
        .dsel        (dsel),
        .dep         (dep),
        .sw          (sw),
        .single_step (single_step),
        .halt        (halt),
        .examn       (examn),
        .contn       (contn),
        .extd_addrn  (extd_addrn),
        .addr_loadn  (addr_loadn),
        .clearn      (clearn),
        .pnl         (pnl.source)
    );

    serial_tx u_serial_tx (.clk12(clk12), .reset(reset), .tx(tx), .tx_char(tx_char));

    serial_rx u_serial_rx (
        .clk12     (clk12),
        .reset     (reset),
        .rx        (rx),
        .rx_char   (rx_char),
        .rx_strobe (rx_strobe)
    );

    panel_lamps #(.lamp_tick(lamp_tick)) u_panel_lamps (
        .clk12 (clk12),
        .reset (reset),
        .pnl   (pnl.sink),
        .walk  (walk),
        .ema   (ema),
        .addr  (addr)
    );

    display_select u_display_select (
        .clk12     (clk12),
        .reset     (reset),
        .pnl       (pnl.sink),
        .tx_char   (tx_char),
        .rx_char   (rx_char),
        .rx_strobe (rx_strobe),
        .walk      (walk),
        .ds        (ds)
    );

    // lamps are driven active low
    assign run  = ~rx;          // run lamp shows receive activity
    assign runn = ~run;
    assign EMAn = ~ema;
    assign An   = ~addr;
    assign dsn  = ~ds;
    assign led1 = 1'b0;
    assign led2 = 1'b0;

endmodule

/* dv/tb_clock.sv */
// tb_clock: testbench clock at 10 ns and a reset held for the first 3 cycles
`timescale 1ns/1ps

module tb_clock (
    output logic clk12,
    output logic reset
);

    initial begin
        clk12 = 1'b0;
        forever #5 clk12 = ~clk12;
    end

    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk12);
        reset <= 1'b0;              // low from the third rising edge on
    end

endmodule

/* dv/panel_checker.sv */
// panel_checker: assertions on the walking lamp, the address sweep and the idle tx line
`timescale 1ns/1ps

module panel_checker import panel_pkg::*; (
    input  logic               clk12,
    input  logic               reset,
    input  logic               lamps_en,   // set where bound into panel_lamps
    input  word_t              walk,
    input  logic [SWEEP_W-1:0] sweep_cnt,
    input  logic               tx_en,      // set where bound into serial_tx
    input  logic               tx
);

    int fail_count = 0;     // failed assertions, summed into the testbench result

    // never more than one lamp lit
    walk_onehot: assert property (@(posedge clk12) disable iff (reset || !lamps_en)
        $onehot0(walk))
        else begin
            fail_count++;
            $error("walk has more than one bit set");
        end

    sweep_step: assert property (@(posedge clk12) disable iff (reset || !lamps_en)
        !$past(reset) |-> sweep_cnt == $past(sweep_cnt) + 1'b1)
        else begin
            fail_count++;
            $error("sweep counter did not step by one");
        end

    // first reset edge skipped, the frame register is still unknown there
    tx_idle_in_reset: assert property (@(posedge clk12) disable iff (!tx_en)
        (reset && $past(reset)) |-> tx)
        else begin
            fail_count++;
            $error("tx low while reset is asserted");
        end

endmodule

bind panel_lamps panel_checker u_lamps_chk (
    .clk12(clk12), .reset(reset), .lamps_en(1'b1), .walk(walk),
    .sweep_cnt(sweep_cnt), .tx_en(1'b0), .tx(1'b1)
);

bind serial_tx panel_checker u_tx_chk (
    .clk12(clk12), .reset(reset), .lamps_en(1'b0), .walk('0),
    .sweep_cnt('0), .tx_en(1'b1), .tx(tx)
);

/* dv/panel_test_tb.sv */
// panel_test_tb: directed tests of the front-panel lamp and switch test top level
`timescale 1ns/1ps

module panel_test_tb;
    import panel_pkg::*;

    localparam int TB_TICK   = 16;         // short walking lamp period
    localparam int TX_FRAMES = 100;        // enough to pass a line end and the wrap
    localparam int EDGE_WAIT = 12 * BAUD_DIV;

    logic  clk12, reset, rx, dep, sw, single_step, halt;
    logic  examn, contn, extd_addrn, addr_loadn, clearn;
    logic  led1, led2, runn, tx;
    word_t sr, An, dsn;
    dsel_t dsel;
    ema_t  EMAn;

    int          errors = 0;
    int          checks = 0;
    logic [31:0] rng = 32'h4cad;

    tb_clock u_clock (.clk12(clk12), .reset(reset));

    panel_test_top #(.lamp_tick(TB_TICK)) dut (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        return s;
    endfunction

    function automatic word_t one_bit(input int i);
        word_t w;
        w    = '0;
        w[i] = 1'b1;
        return w;
    endfunction

    function automatic dsel_t sel(input int b);
        dsel_t d;
        d    = '0;
        d[b] = 1'b1;
        return d;
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %0t ns %s expected %o got %o", $time, name, exp, act);
        end
    endtask

    task automatic check_char(input string name, input char_t exp, input char_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %0t ns %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_ema(input string name, input ema_t exp, input ema_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %0t ns %s expected %o got %o", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %0t ns %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    // waits for the data lamps to show exp, then checks them
    task automatic wait_ds(input word_t exp, input int limit, input string what);
        int t;
        t = 0;
        while (~dsn !== exp && t < limit) begin
            @(negedge clk12);
            t++;
        end
        if (~dsn !== exp)
            $display("timed out after %0d cycles waiting for %s on the data lamps", t, what);
        check_word({what, " on dsn"}, exp, ~dsn);
    endtask

    task automatic wait_change(input int limit);
        word_t last;
        int    t;
        last = ~dsn;
        t    = 0;
        while (~dsn === last && t < limit) begin
            @(negedge clk12);
            t++;
        end
        if (~dsn === last) begin
            errors++;
            $display("data lamps did not change within %0d cycles", limit);
        end
    endtask

    task automatic set_keys(input logic [0:8] k);   // active high, panel_if order
        @(posedge clk12);
        sw          <= k[0];
        addr_loadn  <= ~k[1];
        extd_addrn  <= ~k[2];
        clearn      <= ~k[3];
        contn       <= ~k[4];
        examn       <= ~k[5];
        halt        <= k[6];
        single_step <= k[7];
        dep         <= k[8];
    endtask

    // decodes one 8N1 frame from tx, sampling mid-bit
    task automatic read_frame(output char_t c, output logic ok);
        logic prev;
        int   t;
        int   i;
        ok = 1'b0;
        c  = '0;
        t  = 0;
        do begin
            prev = tx;
            @(negedge clk12);
            t++;
        end while (!(prev && !tx) && t < EDGE_WAIT);
        if (!(prev && !tx)) begin
            errors++;
            $display("no start bit seen on tx within %0d cycles", EDGE_WAIT);
            return;
        end
        repeat (BAUD_DIV / 2) @(negedge clk12);
        if (tx !== 1'b0) begin
            errors++;
            $display("start bit on tx did not stay low");
            return;
        end
        for (i = 0; i < 8; i++) begin
            repeat (BAUD_DIV) @(negedge clk12);
            c[i] = tx;                       // lsb first
        end
        repeat (BAUD_DIV) @(negedge clk12);
        if (tx !== 1'b1) begin
            errors++;
            $display("stop bit on tx was low");
            return;
        end
        ok = 1'b1;
    endtask

    task automatic send_frame(input char_t c, input logic stop_bit);
        int i;
        @(posedge clk12);
        rx <= 1'b0;
        @(negedge clk12);
        check_bit("runn", 1'b0, runn);      // run lamp lit during the start bit
        repeat (BAUD_DIV) @(posedge clk12);
        for (i = 0; i < 8; i++) begin
            rx <= c[i];
            repeat (BAUD_DIV) @(posedge clk12);
        end
        rx <= stop_bit;
        repeat (BAUD_DIV) @(posedge clk12);
        rx <= 1'b1;
    endtask

    task automatic test_reset();
        int t;
        @(negedge clk12);
        check_word("dsn in reset", 12'o7777, dsn);
        check_bit("tx in reset", 1'b1, tx);
        check_bit("runn", rx, runn);
        t = 0;
        while (reset && t < 20) begin
            @(negedge clk12);
            t++;
        end
        if (reset) begin
            errors++;
            $display("reset was never released");
        end
        check_ema("EMAn after reset", 3'o7, EMAn);
        check_word("An after reset", 12'o7777, An);
        check_word("dsn after reset", 12'o7777, dsn);
        check_bit("led1", 1'b0, led1);
        check_bit("led2", 1'b0, led2);
    endtask

    task automatic test_transmit();
        char_t exp_c;
        char_t pr;
        char_t got;
        int    col;
        int    n;
        logic  ok;
        @(posedge clk12);
        dsel <= sel(0);
        pr  = FIRST_CHAR;
        col = 0;
        for (n = 0; n < TX_FRAMES; n++) begin
            if (col == LINE_COLS) begin
                exp_c = CR_CHAR;
                col++;
            end else if (col == LINE_COLS + 1) begin
                exp_c = LF_CHAR;
                col   = 0;
            end else begin
                exp_c = pr;
                pr    = (pr == LAST_CHAR) ? FIRST_CHAR : pr + 8'd1;
                col++;
            end
            read_frame(got, ok);
            if (!ok)
                break;
            check_char("tx character", exp_c, got);
            check_word("tx_char on dsn", {4'b0000, exp_c}, ~dsn);
        end
    endtask

    task automatic test_switches();
        word_t val;
        int    n;
        for (n = 0; n < 8; n++) begin
            rng = xorshift32(rng);
            val = rng[11:0];
            @(posedge clk12);
            dsel <= sel(1);
            sr   <= val;
            wait_ds(val, 10, "switch register");
        end
    endtask

    task automatic test_keys();
        logic [0:8] k;
        word_t      exp;
        int         n;
        @(posedge clk12);
        dsel <= sel(2);
        for (n = 0; n < 13; n++) begin
            if (n < 9) begin
                k    = '0;
                k[n] = 1'b1;                 // one key at a time
            end else begin
                rng = xorshift32(rng);
                k   = rng[8:0];
            end
            set_keys(k);
            exp      = '0;
            exp[0:8] = k;
            wait_ds(exp, 10, "keys");
        end
        set_keys('0);
    endtask

    task automatic test_receive();
        char_t c;
        char_t held;
        int    n;
        @(posedge clk12);
        dsel <= sel(5);
        for (n = 0; n < 6; n++) begin
            rng = xorshift32(rng);
            c   = rng[7:0];
            send_frame(c, 1'b1);
            wait_ds({4'b0000, c}, BAUD_DIV, "received character");
            held = c;
        end
        // low stop bit, the display keeps the previous character
        send_frame(~held, 1'b0);
        repeat (BAUD_DIV) @(negedge clk12);
        check_word("dsn after framing error", {4'b0000, held}, ~dsn);
        rng = xorshift32(rng);
        c   = rng[7:0];
        send_frame(c, 1'b1);
        wait_ds({4'b0000, c}, BAUD_DIV, "received character");
    endtask

    task automatic run_walk(input int dir_bit);
        int seed_idx;
        int idx;
        int step;
        seed_idx = (dir_bit == 4) ? 0 : 11;
        @(posedge clk12);
        dsel <= sel(dir_bit);
        wait_ds(one_bit(seed_idx), 16 * TB_TICK, "walk seed");
        for (step = 1; step < 12; step++) begin
            wait_change(4 * TB_TICK);
            idx = (dir_bit == 4) ? step : 11 - step;
            check_word("walk on dsn", ~one_bit(idx), dsn);
        end
        wait_change(4 * TB_TICK);
        check_word("walk on dsn", 12'o7777, dsn);   // all dark before the reload
        wait_change(4 * TB_TICK);
        check_word("walk on dsn", ~one_bit(seed_idx), dsn);
    endtask

    task automatic test_sweep();
        logic [14:0] a0;
        ema_t        exp_ema;
        word_t       exp_addr;
        @(negedge clk12);
        a0 = ~{EMAn, An};
        repeat (1 << SWEEP_SHIFT) @(negedge clk12);
        {exp_ema, exp_addr} = a0 + 15'd1;
        check_ema("EMA lamps", exp_ema, ~EMAn);
        check_word("address lamps", exp_addr, ~An);
    endtask

    initial begin
        rx          = 1'b1;
        sr          = '0;
        dsel        = '0;
        dep         = 1'b0;
        sw          = 1'b0;
        single_step = 1'b0;
        halt        = 1'b0;
        examn       = 1'b1;
        contn       = 1'b1;
        extd_addrn  = 1'b1;
        addr_loadn  = 1'b1;
        clearn      = 1'b1;

        test_reset();
        test_transmit();        // must follow reset, the stream starts at FIRST_CHAR
        test_switches();
        test_keys();
        test_receive();
        run_walk(4);
        run_walk(3);
        test_sweep();

        // assertion failures in the bound checkers count as errors too
        errors += dut.u_panel_lamps.u_lamps_chk.fail_count;
        errors += dut.u_serial_tx.u_tx_chk.fail_count;

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

/* all.f */
common/panel_pkg.sv
common/panel_if.sv
logic/switch_sync.sv
serial/serial_tx.sv
serial/serial_rx.sv
logic/panel_lamps.sv
logic/display_select.sv
logic/panel_test_top.sv
dv/tb_clock.sv
dv/panel_checker.sv
dv/panel_test_tb.sv
